// File: Makefile
VERILATOR ?= verilator
TOP       ?= mdv_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: include/mdv_tb_util.svh
`ifndef MDV_TB_UTIL_SVH
`define MDV_TB_UTIL_SVH

// ====================
// Wait limits
// ====================
localparam int POLL_LIMIT = TB_GAP_CYCLES;      // IRQ register polls of 2 clocks
localparam int EDGE_LIMIT = 2 * TB_GAP_CYCLES;  // Clock edges for a flag to rise

logic [31:0] lfsr_state = 32'he34a2bd4;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One step per bit
function automatic logic [7:0] rand_byte();
  logic [7:0] b;
  b = 8'h00;
  for (int i = 0; i < 8; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    b = {b[6:0], lfsr_state[0]};
  end
  return b;
endfunction

// ====================
// Typed compares
// ====================
task automatic check_status(input string name, input status_t got, input status_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp));
  end
endtask

task automatic check_pending(input string name, input pending_t got, input pending_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp));
  end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    stop_on_error($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_on_error($sformatf("MISMATCH %s got 0x%1h expected 0x%1h", name, got, exp));
  end
endtask

`endif

// File: dv/mdv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mdv_tb import mdv_pkg::*; ();

  localparam int TB_GAP_CYCLES = 1500;  // Gap outlasts a full host load
  localparam int TB_DEPTH      = 1024;

  logic       clk_cpu;
  logic       reset;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  host_wr_t   host;
  logic [7:0] host_rdata;
  logic       host_req;
  logic       gap_irq;

  // Expected model
  logic [7:0]        exp_mem [TB_DEPTH];
  logic [BUF_AW-1:0] exp_addr;
  logic [7:0]        exp_mctrl;
  logic [7:0]        exp_sel;
  logic              exp_mask;
  logic              exp_gap_irq;
  mdv_state_e        exp_state;
  logic [8:0]        rd_q [$];  // {reading, byte} per DATA read

  `include "mdv_tb_util.svh"

  mdv_top #(
    .GAP_CYCLES (TB_GAP_CYCLES),
    .BUF_DEPTH  (TB_DEPTH)
  ) uut (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_apb        (apb_req),
    .i_host       (host),
    .o_apb        (apb_rsp),
    .o_host_rdata (host_rdata),
    .o_host_req   (host_req),
    .o_gap_irq    (gap_irq)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic logic [7:0] ref_data_read(input logic reading);
    logic [7:0] b;
    b = exp_mem[exp_addr];
    if (reading) begin
      exp_addr = exp_addr + 1'b1;  // Wraps at the sector end
    end
    return b;
  endfunction

  function automatic void ref_ctrl_write(input logic [7:0] wdata);
    if (exp_mctrl[1] && !wdata[1]) begin
      exp_sel   = {exp_sel[6:0], wdata[0]};
      exp_state = wdata[0] ? MDV_GAP : MDV_IDLE;
    end
    exp_mctrl = wdata;
  endfunction

  function automatic void ref_irq_write(input logic [7:0] wdata);
    exp_mask = wdata[5];
    if (wdata[0]) begin
      exp_gap_irq = 1'b0;
    end
  endfunction

  function automatic status_t ref_status();
    status_t s;
    s = '0;
    s.gap_present = (exp_state == MDV_GAP);
    s.reading     = (exp_state == MDV_READING);
    return s;
  endfunction

  function automatic pending_t ref_pending();
    pending_t p;
    p = '0;
    p.no_drive = (exp_sel == 8'h00);
    p.gap_irq  = exp_gap_irq;
    return p;
  endfunction

  // DATA bytes checked in read order
  initial begin
    logic [8:0] rec;
    forever begin
      @(posedge clk_cpu);
      while (rd_q.size() > 0) begin
        rec = rd_q.pop_front();
        check_byte("o_apb.prdata", rec[7:0], ref_data_read(rec[8]));
      end
    end
  end

  // ====================
  // Bus drivers
  // ====================
  task automatic apb_write(input logic [3:0] addr, input logic [15:0] data);
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
    @(posedge clk_cpu);
    #1 apb_req.penable = 1'b1;
    @(posedge clk_cpu);
    #1 apb_req = '0;
    if (addr == REG_CTRL) begin
      ref_ctrl_write(data[7:0]);
    end else if (addr == REG_IRQ) begin
      ref_irq_write(data[7:0]);
    end
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [15:0] data);
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: 16'h0000};
    @(posedge clk_cpu);
    #1 apb_req.penable = 1'b1;
    @(negedge clk_cpu);  // Mid access phase
    data = apb_rsp.prdata;
    check_bit("o_apb.pready", apb_rsp.pready, 1'b1);
    check_bit("o_apb.pslverr", apb_rsp.pslverr, 1'b0);
    @(posedge clk_cpu);
    #1 apb_req = '0;
  endtask

  task automatic data_read();
    logic [15:0] d;
    apb_read(REG_DATA, d);
    rd_q.push_back({exp_state == MDV_READING, d[7:0]});
  endtask

  task automatic irq_read(output status_t st, output pending_t pd);
    logic [15:0] d;
    apb_read(REG_IRQ, d);
    st = d[15:8];
    pd = d[7:0];
  endtask

  task automatic check_irq_reg();
    status_t  st;
    pending_t pd;
    irq_read(st, pd);
    check_status("status", st, ref_status());
    check_pending("pending", pd, ref_pending());
  endtask

  task automatic check_ctrl_reg();
    logic [15:0] d;
    apb_read(REG_CTRL, d);
    check_byte("o_apb.prdata[15:8]", d[15:8], 8'h00);
    check_byte("mctrl", d[7:0], exp_mctrl);
  endtask

  task automatic check_unmapped_read();
    logic [15:0] d;
    apb_read(4'hC, d);  // No register here
    check_byte("o_apb.prdata[15:8]", d[15:8], 8'h00);
    check_byte("o_apb.prdata[7:0]", d[7:0], 8'h00);
  endtask

  task automatic host_write(input logic [BUF_AW-1:0] addr, input logic [7:0] data);
    host = '{wr: 1'b1, addr: addr, data: data};
    @(posedge clk_cpu);
    #1 host.wr = 1'b0;
  endtask

  task automatic host_readback(input logic [BUF_AW-1:0] addr);
    host = '{wr: 1'b0, addr: addr, data: 8'h00};
    @(posedge clk_cpu);
    @(negedge clk_cpu);
    check_byte("o_host_rdata", host_rdata, exp_mem[addr]);
    @(posedge clk_cpu);
    #1;
  endtask

  // ====================
  // Waits
  // ====================
  task automatic wait_state(input mdv_state_e want);
    status_t  st;
    pending_t pd;
    int       polls;
    polls = 0;
    irq_read(st, pd);
    while (!((want == MDV_GAP) ? st.gap_present : st.reading)) begin
      if (!exp_mask) begin
        check_bit("o_gap_irq", gap_irq, 1'b0);
      end
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_on_error("timed out waiting for the drive to change state");
      end
      irq_read(st, pd);
    end
    exp_state = want;
    if (want == MDV_READING) begin
      exp_addr = '0;  // Every read pass starts at the top
    end
  endtask

  task automatic wait_flag(input bit use_irq);
    int cycles;
    cycles = 0;
    while ((use_irq ? gap_irq : host_req) !== 1'b1) begin
      cycles++;
      if (cycles > EDGE_LIMIT) begin
        stop_on_error(use_irq ? "o_gap_irq never rose" : "o_host_req never rose");
      end
      @(posedge clk_cpu);
      #1;
    end
  endtask

  task automatic wait_compare_done();
    int cycles;
    cycles = 0;
    while (rd_q.size() > 0) begin
      cycles++;
      if (cycles > 4) begin
        stop_on_error("compare process did not drain the read queue");
      end
      @(posedge clk_cpu);
      #1;
    end
  endtask

  // ====================
  // Sequence
  // ====================
  initial begin
    logic [BUF_AW-1:0] a;
    reset       = 1'b1;
    apb_req     = '0;
    host        = '0;
    exp_addr    = '0;
    exp_mctrl   = 8'h00;
    exp_sel     = 8'h00;
    exp_mask    = 1'b0;
    exp_gap_irq = 1'b0;
    exp_state   = MDV_IDLE;
    repeat (2) @(posedge clk_cpu);
    #1 reset = 1'b0;

    check_irq_reg();
    check_unmapped_read();
    check_bit("o_host_req", host_req, 1'b0);
    check_bit("o_gap_irq", gap_irq, 1'b0);

    apb_write(REG_CTRL, 16'h0002);
    apb_write(REG_CTRL, 16'h0001);  // Clock edge shifts in a 1
    check_irq_reg();
    check_ctrl_reg();
    wait_flag(1'b0);

    // Sector load inside the first gap with mask still 0
    for (int i = 0; i < TB_DEPTH; i++) begin
      a = BUF_AW'(i);
      exp_mem[a] = rand_byte();
      check_bit("o_host_req", host_req, 1'b1);
      check_bit("o_gap_irq", gap_irq, 1'b0);
      host_write(a, exp_mem[a]);
    end
    check_bit("o_host_req", host_req, 1'b0);
    for (int k = 0; k < 8; k++) begin
      host_readback(BUF_AW'(k * 146 + 1));
    end

    wait_state(MDV_READING);
    repeat (TB_DEPTH) data_read();
    wait_compare_done();

    // Host writes under the reader are dropped
    repeat (5) data_read();
    wait_compare_done();
    for (int k = 0; k < 4; k++) begin
      a = exp_addr + BUF_AW'(k);
      host_write(a, ~exp_mem[a]);
    end
    for (int k = 0; k < 4; k++) begin
      host_readback(exp_addr + BUF_AW'(k));
    end
    repeat (8) data_read();
    wait_compare_done();

    wait_state(MDV_GAP);  // Reader idle too long
    check_irq_reg();

    apb_write(REG_IRQ, 16'h0020);
    wait_flag(1'b1);
    exp_gap_irq = exp_mask && (exp_state == MDV_GAP);
    check_irq_reg();
    apb_write(REG_IRQ, 16'h0001);  // Mask off and ack
    check_bit("o_gap_irq", gap_irq, 1'b0);
    check_irq_reg();

    wait_state(MDV_READING);
    repeat (4) data_read();
    wait_compare_done();

    apb_write(REG_CTRL, 16'h0002);
    apb_write(REG_CTRL, 16'h0000);  // Deselect
    check_irq_reg();
    check_ctrl_reg();
    check_bit("o_host_req", host_req, 1'b0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/mdv_drive.sv
`timescale 1ns/1ps
`default_nettype none

module mdv_drive import mdv_pkg::*; #(
  parameter int GAP_CYCLES = 200,
  parameter int BUF_DEPTH  = 1024
) (
  input  wire logic              clk_cpu,
  input  wire logic              reset,
  input  wire apb_req_t          i_apb,
  input  wire logic [7:0]        i_buf_rdata,
  output apb_rsp_t               o_apb,
  output logic [BUF_AW-1:0]      o_buf_addr,
  output logic                   o_reading,
  output logic                   o_gap_start,
  output logic                   o_idle,
  output logic                   o_gap_irq
);

  localparam int CNT_W = $clog2(GAP_CYCLES + 1);
  localparam logic [CNT_W-1:0]  CNT_LAST  = CNT_W'(GAP_CYCLES - 1);
  localparam logic [BUF_AW-1:0] ADDR_LAST = BUF_AW'(BUF_DEPTH - 1);

  mdv_state_e        state, state_nxt;
  logic [CNT_W-1:0]  cnt, cnt_nxt;     // Gap length and read-idle timeout
  logic [BUF_AW-1:0] rd_addr, addr_nxt;
  logic [7:0]        mctrl;
  logic [7:0]        sel;              // Drive select shift register
  logic              gap_mask;
  logic              gap_irq;
  logic              gap_start;
  logic              gap_entry;

  logic     access;
  logic     ctrl_wr, irq_wr, data_rd;
  logic     sel_clk;
  logic     gap_ack;
  status_t  status;
  pending_t pending;

  // ====================
  // APB decode
  // ====================
  assign access  = i_apb.psel && i_apb.penable;
  assign ctrl_wr = access && i_apb.pwrite && (i_apb.paddr == REG_CTRL);
  assign irq_wr  = access && i_apb.pwrite && (i_apb.paddr == REG_IRQ);
  assign data_rd = access && !i_apb.pwrite && (i_apb.paddr == REG_DATA);

  // Falling edge of the select clock bit, new bit 0 shifts in
  assign sel_clk = ctrl_wr && !i_apb.pwdata[1] && mctrl[1];
  assign gap_ack = irq_wr && i_apb.pwdata[0];  // Ack bit 0 only has a source here

  always_comb begin
    status             = '0;
    status.gap_present = (state == MDV_GAP);
    status.reading     = (state == MDV_READING);
    pending            = '0;
    pending.no_drive   = (sel == 8'h00);
    pending.gap_irq    = gap_irq;
  end

  always_comb begin
    o_apb.pready  = 1'b1;  // Zero wait states
    o_apb.pslverr = 1'b0;
    case (i_apb.paddr)
      REG_CTRL: o_apb.prdata = {8'h00, mctrl};
      REG_IRQ:  o_apb.prdata = {status, pending};
      REG_DATA: o_apb.prdata = {i_buf_rdata, i_buf_rdata};
      default:  o_apb.prdata = 16'h0000;
    endcase
  end

  // ====================
  // Drive FSM
  // ====================
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    addr_nxt  = rd_addr;
    gap_entry = 1'b0;
    case (state)
      MDV_GAP: begin
        if (cnt == CNT_LAST) begin
          state_nxt = MDV_READING;  // Sector starts from the top
          cnt_nxt   = '0;
          addr_nxt  = '0;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end
      MDV_READING: begin
        if (data_rd) begin
          addr_nxt = (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;
          cnt_nxt  = '0;  // Restart idle timeout
        end else if (cnt == CNT_LAST) begin
          state_nxt = MDV_GAP;  // Reader went quiet
          cnt_nxt   = '0;
          gap_entry = 1'b1;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end
      default: cnt_nxt = '0;
    endcase

    // Select write overrides any timing in progress
    if (sel_clk) begin
      cnt_nxt   = '0;
      state_nxt = i_apb.pwdata[0] ? MDV_GAP : MDV_IDLE;
      gap_entry = i_apb.pwdata[0];
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state     <= MDV_IDLE;
      cnt       <= '0;
      rd_addr   <= '0;
      mctrl     <= 8'h00;
      sel       <= 8'h00;
      gap_mask  <= 1'b0;
      gap_irq   <= 1'b0;
      gap_start <= 1'b0;
    end else begin
      state     <= state_nxt;
      cnt       <= cnt_nxt;
      rd_addr   <= addr_nxt;
      gap_start <= gap_entry;  // High in the first GAP cycle
      if (ctrl_wr) begin
        mctrl <= i_apb.pwdata[7:0];
      end
      if (sel_clk) begin
        sel <= {sel[6:0], i_apb.pwdata[0]};
      end
      if (irq_wr) begin
        gap_mask <= i_apb.pwdata[5];  // Mask bit 0 of pwdata[7:5]
      end
      // Ack beats a fresh set
      if (gap_ack) begin
        gap_irq <= 1'b0;
      end else if ((state == MDV_GAP) && gap_mask) begin
        gap_irq <= 1'b1;
      end
    end
  end

  assign o_buf_addr  = rd_addr;
  assign o_reading   = (state == MDV_READING);
  assign o_idle      = (state == MDV_IDLE);
  assign o_gap_start = gap_start;
  assign o_gap_irq   = gap_irq;

endmodule

`default_nettype wire

// File: hdl/mdv_host_loader.sv
`timescale 1ns/1ps
`default_nettype none

module mdv_host_loader import mdv_pkg::*; #(
  parameter int BUF_DEPTH = 1024
) (
  input  wire logic              clk_cpu,
  input  wire logic              reset,
  input  wire host_wr_t          i_host,
  input  wire logic              i_reading,
  input  wire logic              i_gap_start,
  input  wire logic              i_idle,
  output logic                   o_buf_we,
  output logic [BUF_AW-1:0]      o_buf_addr,
  output logic [7:0]             o_buf_wdata,
  output logic                   o_host_req
);

  localparam logic [BUF_AW-1:0] LAST_ADDR = BUF_AW'(BUF_DEPTH - 1);

  logic host_req;
  logic last_wr;

  // ====================
  // Buffer port A
  // ====================

  // Sector must not change under the reader
  assign o_buf_we    = i_host.wr && !i_reading;
  assign o_buf_addr  = i_host.addr;  // Also the read-back address
  assign o_buf_wdata = i_host.data;

  // Host has delivered the final byte of the sector
  assign last_wr = o_buf_we && (i_host.addr == LAST_ADDR);

  // ====================
  // Data request flag
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      host_req <= 1'b0;
    end else if (i_idle) begin
      host_req <= 1'b0;  // Drive deselected
    end else if (i_gap_start) begin
      host_req <= 1'b1;
    end else if (last_wr) begin
      host_req <= 1'b0;
    end
  end

  assign o_host_req = host_req;

endmodule

`default_nettype wire

// File: hdl/mdv_pkg.sv
`default_nettype none

package mdv_pkg;

  // ====================
  // Buffer geometry
  // ====================
  localparam int BUF_AW = 10;  // 1 KB sector

  // ====================
  // APB register map
  // ====================
  localparam logic [3:0] REG_CTRL = 4'h0;  // mctrl, drive select clocking
  localparam logic [3:0] REG_IRQ  = 4'h4;  // W: mask/ack, R: status/pending
  localparam logic [3:0] REG_DATA = 4'h8;  // Sector byte stream

  typedef struct packed {
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Byte write from the host side loader
  typedef struct packed {
    logic              wr;
    logic [BUF_AW-1:0] addr;
    logic [7:0]        data;
  } host_wr_t;

  typedef enum logic [1:0] {
    MDV_IDLE    = 2'd0,
    MDV_GAP     = 2'd1,
    MDV_READING = 2'd2
  } mdv_state_e;

  // Upper byte of an IRQ read
  typedef struct packed {
    logic [3:0] rsvd_hi;
    logic       gap_present;  // Bit 3
    logic       reading;      // Bit 2, drive is streaming the sector
    logic [1:0] rsvd_lo;
  } status_t;

  // Lower byte of an IRQ read
  typedef struct packed {
    logic       rsvd_hi;
    logic       no_drive;  // Bit 6, select register empty
    logic [4:0] rsvd_mid;
    logic       gap_irq;   // Bit 0
  } pending_t;

endpackage

`default_nettype wire

// File: hdl/mdv_sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mdv_sector_buffer import mdv_pkg::*; #(
  parameter int BUF_DEPTH = 1024
) (
  input  wire logic              clk_cpu,
  input  wire logic              i_we,
  input  wire logic [BUF_AW-1:0] i_addr_a,
  input  wire logic [7:0]        i_wdata,
  input  wire logic [BUF_AW-1:0] i_addr_b,
  output logic [7:0]             o_rdata_a,
  output logic [7:0]             o_rdata_b
);

  logic [7:0] mem [BUF_DEPTH];

  // Port A: host write and read-back
  always_ff @(posedge clk_cpu) begin
    if (i_we) begin
      mem[i_addr_a] <= i_wdata;
    end
    o_rdata_a <= mem[i_addr_a];  // Old data on a write cycle
  end

  // Port B: drive side, read only
  always_ff @(posedge clk_cpu) begin
    o_rdata_b <= mem[i_addr_b];
  end

endmodule

`default_nettype wire

// File: hdl/mdv_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdv_top import mdv_pkg::*; #(
  parameter int GAP_CYCLES = 200,   // Gap length in clk_cpu cycles
  parameter int BUF_DEPTH  = 1024
) (
  input  wire logic     clk_cpu,
  input  wire logic     reset,
  input  wire apb_req_t i_apb,
  input  wire host_wr_t i_host,
  output apb_rsp_t      o_apb,
  output logic [7:0]    o_host_rdata,
  output logic          o_host_req,
  output logic          o_gap_irq
);

  logic              buf_we;
  logic [BUF_AW-1:0] buf_addr_a;
  logic [7:0]        buf_wdata;
  logic [BUF_AW-1:0] buf_addr_b;
  logic [7:0]        buf_rdata_b;
  logic              reading;
  logic              gap_start;
  logic              idle;

  // ====================
  // Host side
  // ====================
  mdv_host_loader #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_loader (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_host      (i_host),
    .i_reading   (reading),
    .i_gap_start (gap_start),
    .i_idle      (idle),
    .o_buf_we    (buf_we),
    .o_buf_addr  (buf_addr_a),
    .o_buf_wdata (buf_wdata),
    .o_host_req  (o_host_req)
  );

  mdv_sector_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_buffer (
    .clk_cpu   (clk_cpu),
    .i_we      (buf_we),
    .i_addr_a  (buf_addr_a),
    .i_wdata   (buf_wdata),
    .i_addr_b  (buf_addr_b),
    .o_rdata_a (o_host_rdata),
    .o_rdata_b (buf_rdata_b)
  );

  // ====================
  // QL side
  // ====================
  mdv_drive #(
    .GAP_CYCLES (GAP_CYCLES),
    .BUF_DEPTH  (BUF_DEPTH)
  ) u_drive (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_apb       (i_apb),
    .i_buf_rdata (buf_rdata_b),
    .o_apb       (o_apb),
    .o_buf_addr  (buf_addr_b),
    .o_reading   (reading),
    .o_gap_start (gap_start),
    .o_idle      (idle),
    .o_gap_irq   (o_gap_irq)
  );

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/mdv_pkg.sv
hdl/mdv_host_loader.sv
hdl/mdv_sector_buffer.sv
hdl/mdv_drive.sv
hdl/mdv_top.sv
dv/mdv_tb.sv
